//--- verilog/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`define XLEN 32     // data and address width
`define REG_AW 5    // 32 architectural registers

`endif

//--- verilog/mipsPkg.sv
`include "mips_consts.svh"

package mipsPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_ADDIU   = 6'b001001,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcodeT;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpT;

    // operand source in EX
    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_M  = 2'd1,
        FWD_W  = 2'd2
    } fwdSelT;

    typedef struct packed {
        logic  regWrite;
        logic  regDstRd;    // rd is the destination, else rt
        logic  aluSrcImm;
        logic  memRead;
        logic  memWrite;
        logic  branchEq;
        logic  branchNe;
        logic  jump;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT               ctrl;
        logic [`XLEN-1:0]   pcPlus4;
        logic [`XLEN-1:0]   rd1;
        logic [`XLEN-1:0]   rd2;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] dst;
        logic [`XLEN-1:0]   imm;        // sign extended
        logic [`XLEN-1:0]   jumpTarget;
    } idExT;

    typedef struct packed {
        logic               regWrite;
        logic               memRead;
        logic               memWrite;
        logic [`XLEN-1:0]   aluOut;     // also the memory address
        logic [`XLEN-1:0]   storeData;
        logic [`REG_AW-1:0] dst;
    } exMemT;

    typedef struct packed {
        logic               regWrite;
        logic [`REG_AW-1:0] dst;
        logic [`XLEN-1:0]   result;
    } memWbT;

endpackage

//--- verilog/alu.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module alu (
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,
    input  mipsPkg::aluOpT   op_i,
    output logic [`XLEN-1:0] result_o,
    output logic             zero_o
);

    always_comb begin
        case (op_i)
            mipsPkg::ALU_ADD: result_o = a_i + b_i;     // wraps, no overflow trap
            mipsPkg::ALU_SUB: result_o = a_i - b_i;
            mipsPkg::ALU_AND: result_o = a_i & b_i;
            mipsPkg::ALU_OR:  result_o = a_i | b_i;
            mipsPkg::ALU_SLT: result_o = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            default:          result_o = '0;
        endcase
    end

    // beq/bne look only at this
    assign zero_o = (result_o == '0);

endmodule

//--- verilog/regFile.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module regFile (
    input  logic               clk_i,
    input  logic [`REG_AW-1:0] raddr1_i,
    input  logic [`REG_AW-1:0] raddr2_i,
    output logic [`XLEN-1:0]   rdata1_o,
    output logic [`XLEN-1:0]   rdata2_o,
    input  logic               we_i,
    input  logic [`REG_AW-1:0] waddr_i,
    input  logic [`XLEN-1:0]   wdata_i
);

    logic [`XLEN-1:0] regs [0:(1<<`REG_AW)-1];

    // W write is visible to D in the same cycle
    function automatic logic [`XLEN-1:0] readPort(input logic [`REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (we_i && waddr_i == addr)
            return wdata_i;
        return regs[addr];
    endfunction

    always_comb begin
        rdata1_o = readPort(raddr1_i);
        rdata2_o = readPort(raddr2_i);
    end

    always_ff @(posedge clk_i) begin
        if (we_i && waddr_i != '0)
            regs[waddr_i] <= wdata_i;
    end

endmodule

//--- verilog/mainDecoder.sv
`timescale 1ns/100ps

module mainDecoder (
    input  logic [31:0]   instrD_i,
    output mipsPkg::ctrlT ctrlD_o
);

    mipsPkg::opcodeT opcode;
    logic [5:0]      funct;

    assign opcode = mipsPkg::opcodeT'(instrD_i[31:26]);
    assign funct  = instrD_i[5:0];

    always_comb begin
        ctrlD_o = '0;   // anything unknown is a no-op
        case (opcode)
            mipsPkg::OP_SPECIAL: begin
                ctrlD_o.regWrite = 1'b1;
                ctrlD_o.regDstRd = 1'b1;
                case (funct)
                    6'h21:   ctrlD_o.aluOp = mipsPkg::ALU_ADD;  // addu
                    6'h23:   ctrlD_o.aluOp = mipsPkg::ALU_SUB;  // subu
                    6'h24:   ctrlD_o.aluOp = mipsPkg::ALU_AND;
                    6'h25:   ctrlD_o.aluOp = mipsPkg::ALU_OR;
                    6'h2a:   ctrlD_o.aluOp = mipsPkg::ALU_SLT;
                    default: ctrlD_o = '0;  // incl. sll $0 nop
                endcase
            end
            mipsPkg::OP_ADDIU: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.aluSrcImm = 1'b1;
            end
            mipsPkg::OP_LW: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.aluSrcImm = 1'b1;
                ctrlD_o.memRead   = 1'b1;
            end
            mipsPkg::OP_SW: begin
                ctrlD_o.aluSrcImm = 1'b1;
                ctrlD_o.memWrite  = 1'b1;
            end
            // compare through subtract and the zero flag
            mipsPkg::OP_BEQ: begin
                ctrlD_o.branchEq = 1'b1;
                ctrlD_o.aluOp    = mipsPkg::ALU_SUB;
            end
            mipsPkg::OP_BNE: begin
                ctrlD_o.branchNe = 1'b1;
                ctrlD_o.aluOp    = mipsPkg::ALU_SUB;
            end
            mipsPkg::OP_J:   ctrlD_o.jump = 1'b1;
            default:         ctrlD_o = '0;
        endcase
    end

endmodule

//--- verilog/hazardUnit.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module hazardUnit (
    input  logic [`REG_AW-1:0] rsD_i, rtD_i, rsE_i, rtE_i,
    input  logic [`REG_AW-1:0] dstE_i, dstM_i, dstW_i,
    input  logic               regWriteE_i, regWriteM_i, regWriteW_i,
    input  logic               memReadE_i,
    input  logic               redirectE_i,
    input  logic               dCacheStall_i,
    output logic               stallF_o, stallD_o, stallAll_o,
    output logic               flushD_o, flushE_o,
    output mipsPkg::fwdSelT    fwdA_o, fwdB_o
);

    logic loadUse;

    // newest producer first, $0 never forwarded
    function automatic mipsPkg::fwdSelT pickSrc(
        input logic [`REG_AW-1:0] src,
        input logic [`REG_AW-1:0] dstM,
        input logic               wrM,
        input logic [`REG_AW-1:0] dstW,
        input logic               wrW
    );
        if (wrM && dstM != '0 && dstM == src)
            return mipsPkg::FWD_M;
        if (wrW && dstW != '0 && dstW == src)
            return mipsPkg::FWD_W;
        return mipsPkg::FWD_RF;
    endfunction

    assign loadUse = memReadE_i && regWriteE_i && dstE_i != '0 &&
                     (dstE_i == rsD_i || dstE_i == rtD_i);

    always_comb begin
        fwdA_o = pickSrc(rsE_i, dstM_i, regWriteM_i, dstW_i, regWriteW_i);
        fwdB_o = pickSrc(rtE_i, dstM_i, regWriteM_i, dstW_i, regWriteW_i);
    end

    always_comb begin
        stallAll_o = dCacheStall_i;
        stallF_o   = 1'b0;
        stallD_o   = 1'b0;
        flushD_o   = 1'b0;
        flushE_o   = 1'b0;
        if (dCacheStall_i) begin
            stallF_o = 1'b1;    // whole pipe frozen
            stallD_o = 1'b1;
        end else if (redirectE_i) begin
            flushD_o = 1'b1;    // drop both wrong-path fetches
            flushE_o = 1'b1;
        end else if (loadUse) begin
            stallF_o = 1'b1;
            stallD_o = 1'b1;
            flushE_o = 1'b1;    // one bubble behind the load
        end
    end

endmodule

//--- verilog/datapath.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module datapath (
    input  logic               clk_i,
    input  logic               rstN_i,
    // fetch
    output logic [`XLEN-1:0]   instAddr_o,
    output logic               instEn_o,
    input  logic [31:0]        instr_i,
    // data memory driven from M
    output logic               memEn_o,
    output logic [`XLEN-1:0]   memAddr_o,
    input  logic [`XLEN-1:0]   memRdata_i,
    output logic [3:0]         memWen_o,
    output logic [`XLEN-1:0]   memWdata_o,
    // decoder
    input  mipsPkg::ctrlT      ctrlD_i,
    output logic [31:0]        instrD_o,
    // hazard unit
    output logic [`REG_AW-1:0] rsD_o, rtD_o, rsE_o, rtE_o,
    output logic [`REG_AW-1:0] dstE_o, dstM_o, dstW_o,
    output logic               regWriteE_o, regWriteM_o, regWriteW_o,
    output logic               memReadE_o,
    output logic               redirectE_o,
    input  logic               stallF_i, stallD_i, stallAll_i,
    input  logic               flushD_i, flushE_i,
    input  mipsPkg::fwdSelT    fwdA_i, fwdB_i
);

    logic [`XLEN-1:0]   pcF, pcPlus4F;
    logic [31:0]        instrD;
    logic [`XLEN-1:0]   pcPlus4D;
    logic [`REG_AW-1:0] rdD;
    logic [`XLEN-1:0]   rd1D, rd2D;
    mipsPkg::idExT      idExD;      // next id/ex contents
    mipsPkg::idExT      idEx;
    logic [`XLEN-1:0]   srcAE, rtValueE, srcBE, aluOutE, targetE;
    logic               zeroE;
    mipsPkg::exMemT     exMem;
    logic [`XLEN-1:0]   resultM;
    mipsPkg::memWbT     memWb;

    function automatic logic [`XLEN-1:0] fwdMux(
        input mipsPkg::fwdSelT  sel,
        input logic [`XLEN-1:0] rf,
        input logic [`XLEN-1:0] m,
        input logic [`XLEN-1:0] w
    );
        case (sel)
            mipsPkg::FWD_M: return m;
            mipsPkg::FWD_W: return w;
            default:        return rf;
        endcase
    endfunction

    // IF
    assign pcPlus4F   = pcF + 32'd4;
    assign instAddr_o = pcF;
    assign instEn_o   = rstN_i & ~stallF_i;    // no fetch in reset or while held

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            pcF <= `RESET_PC;
        end else if (redirectE_o && !stallAll_i) begin
            pcF <= targetE;     // taken branch or j resolved in EX
        end else if (!stallF_i) begin
            pcF <= pcPlus4F;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i || flushD_i) begin
            instrD   <= '0;         // all-zero word decodes as nop
            pcPlus4D <= '0;
        end else if (!stallD_i) begin
            instrD   <= instr_i;
            pcPlus4D <= pcPlus4F;
        end
    end

    // ID
    assign instrD_o = instrD;
    assign rsD_o    = instrD[25:21];
    assign rtD_o    = instrD[20:16];
    assign rdD      = instrD[15:11];

    regFile regFile0 (
        .clk_i(clk_i),
        .raddr1_i(rsD_o), .raddr2_i(rtD_o),
        .rdata1_o(rd1D), .rdata2_o(rd2D),
        .we_i(memWb.regWrite), .waddr_i(memWb.dst), .wdata_i(memWb.result)
    );

    always_comb begin
        idExD.ctrl       = ctrlD_i;
        idExD.pcPlus4    = pcPlus4D;
        idExD.rd1        = rd1D;
        idExD.rd2        = rd2D;
        idExD.rs         = rsD_o;
        idExD.rt         = rtD_o;
        idExD.dst        = ctrlD_i.regDstRd ? rdD : rtD_o;
        idExD.imm        = {{16{instrD[15]}}, instrD[15:0]};
        idExD.jumpTarget = {pcPlus4D[31:28], instrD[25:0], 2'b00};
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i)
            idEx <= '0;
        else if (!stallAll_i) begin
            if (flushE_i)
                idEx <= '0;
            else
                idEx <= idExD;
        end
    end

    // EX
    assign srcAE    = fwdMux(fwdA_i, idEx.rd1, resultM, memWb.result);
    assign rtValueE = fwdMux(fwdB_i, idEx.rd2, resultM, memWb.result);
    assign srcBE    = idEx.ctrl.aluSrcImm ? idEx.imm : rtValueE;

    alu alu0 (
        .a_i(srcAE), .b_i(srcBE), .op_i(idEx.ctrl.aluOp),
        .result_o(aluOutE), .zero_o(zeroE)
    );

    assign redirectE_o = idEx.ctrl.jump | (idEx.ctrl.branchEq & zeroE) |
                         (idEx.ctrl.branchNe & ~zeroE);
    assign targetE = idEx.ctrl.jump ? idEx.jumpTarget
                                    : idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

    assign rsE_o       = idEx.rs;
    assign rtE_o       = idEx.rt;
    assign dstE_o      = idEx.dst;
    assign regWriteE_o = idEx.ctrl.regWrite;
    assign memReadE_o  = idEx.ctrl.memRead;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            exMem <= '0;
        end else if (!stallAll_i) begin
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.memRead   <= idEx.ctrl.memRead;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.aluOut    <= aluOutE;
            exMem.storeData <= rtValueE;    // forwarded rt
            exMem.dst       <= idEx.dst;
        end
    end

    // MEM outputs hold while exMem is frozen
    assign memEn_o     = exMem.memRead | exMem.memWrite;
    assign memAddr_o   = exMem.aluOut;
    assign memWen_o    = {4{exMem.memWrite}};  // word stores only
    assign memWdata_o  = exMem.storeData;
    assign resultM     = exMem.memRead ? memRdata_i : exMem.aluOut;
    assign dstM_o      = exMem.dst;
    assign regWriteM_o = exMem.regWrite;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            memWb <= '0;
        end else if (!stallAll_i) begin
            memWb.regWrite <= exMem.regWrite;
            memWb.dst      <= exMem.dst;
            memWb.result   <= resultM;
        end
    end

    // WB
    assign dstW_o      = memWb.dst;
    assign regWriteW_o = memWb.regWrite;

endmodule

//--- verilog/mipsCore.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module mipsCore (
    input  logic             clk_i,
    input  logic             rstN_i,
    output logic [`XLEN-1:0] instAddr_o,
    output logic             instEn_o,
    input  logic [31:0]      instr_i,
    output logic             memEn_o,
    output logic [`XLEN-1:0] memAddr_o,
    input  logic [`XLEN-1:0] memRdata_i,
    output logic [3:0]       memWen_o,
    output logic [`XLEN-1:0] memWdata_o,
    input  logic             dCacheStall_i
);

    logic [31:0]        instrD;
    mipsPkg::ctrlT      ctrlD;
    logic [`REG_AW-1:0] rsD, rtD, rsE, rtE, dstE, dstM, dstW;
    logic               regWriteE, regWriteM, regWriteW, memReadE, redirectE;
    logic               stallF, stallD, stallAll, flushD, flushE;
    mipsPkg::fwdSelT    fwdA, fwdB;

    datapath datapath0 (
        .clk_i(clk_i), .rstN_i(rstN_i),
        .instAddr_o(instAddr_o), .instEn_o(instEn_o), .instr_i(instr_i),
        .memEn_o(memEn_o), .memAddr_o(memAddr_o), .memRdata_i(memRdata_i),
        .memWen_o(memWen_o), .memWdata_o(memWdata_o),
        .ctrlD_i(ctrlD), .instrD_o(instrD),
        .rsD_o(rsD), .rtD_o(rtD), .rsE_o(rsE), .rtE_o(rtE),
        .dstE_o(dstE), .dstM_o(dstM), .dstW_o(dstW),
        .regWriteE_o(regWriteE), .regWriteM_o(regWriteM), .regWriteW_o(regWriteW),
        .memReadE_o(memReadE), .redirectE_o(redirectE),
        .stallF_i(stallF), .stallD_i(stallD), .stallAll_i(stallAll),
        .flushD_i(flushD), .flushE_i(flushE),
        .fwdA_i(fwdA), .fwdB_i(fwdB)
    );

    mainDecoder mainDecoder0 (
        .instrD_i(instrD),
        .ctrlD_o(ctrlD)
    );

    hazardUnit hazardUnit0 (
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(rsE), .rtE_i(rtE),
        .dstE_i(dstE), .dstM_i(dstM), .dstW_i(dstW),
        .regWriteE_i(regWriteE), .regWriteM_i(regWriteM), .regWriteW_i(regWriteW),
        .memReadE_i(memReadE), .redirectE_i(redirectE),
        .dCacheStall_i(dCacheStall_i),
        .stallF_o(stallF), .stallD_o(stallD), .stallAll_o(stallAll),
        .flushD_o(flushD), .flushE_o(flushE),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

endmodule

//--- verification/mipsCore_props.sv
`timescale 1ns/100ps

module mipsCore_props (
    input logic        clk_i,
    input logic        rstN_i,
    input logic [31:0] instAddr_o,
    input logic        instEn_o,
    input logic        memEn_o,
    input logic [31:0] memAddr_o,
    input logic [3:0]  memWen_o,
    input logic [31:0] memWdata_o,
    input logic        dCacheStall_i
);

    logic   wasInReset = 1'b0;  // reset seen at the previous edge
    integer failCount  = 0;

    always @(posedge clk_i)
        wasInReset <= !rstN_i;

    wenNeedsEn: assert property (@(posedge clk_i) disable iff (!rstN_i)
        memWen_o != 4'h0 |-> memEn_o)
        else begin
            failCount++;
            $error("memWen_o set while memEn_o is low");
        end

    fetchAligned: assert property (@(posedge clk_i) disable iff (!rstN_i)
        instAddr_o[1:0] == 2'b00)
        else begin
            failCount++;
            $error("instAddr_o not word aligned");
        end

    // M stage frozen under a cache stall
    holdOnStall: assert property (@(posedge clk_i) disable iff (!rstN_i)
        dCacheStall_i |=> $stable(memEn_o) && $stable(memAddr_o) &&
                          $stable(memWen_o) && $stable(memWdata_o))
        else begin
            failCount++;
            $error("memory outputs moved during a cache stall");
        end

    quietInReset: assert property (@(posedge clk_i)
        (!rstN_i && wasInReset) |-> !memEn_o && memWen_o == 4'h0 && !instEn_o)
        else begin
            failCount++;
            $error("control outputs active during reset");
        end

endmodule

bind mipsCore mipsCore_props props0 (
    .clk_i(clk_i), .rstN_i(rstN_i),
    .instAddr_o(instAddr_o), .instEn_o(instEn_o),
    .memEn_o(memEn_o), .memAddr_o(memAddr_o),
    .memWen_o(memWen_o), .memWdata_o(memWdata_o),
    .dCacheStall_i(dCacheStall_i)
);

//--- verification/mipsCoreTb.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module mipsCoreTb;

    localparam integer DUMP_AT     = 195;   // 15 init words then 180 random ones
    localparam integer LOOP_AT     = 210;
    localparam integer PROG_LEN    = LOOP_AT + 1;
    localparam integer CYCLE_LIMIT = PROG_LEN * 8 + 100;

    localparam logic [5:0] F_ADDU = 6'h21;
    localparam logic [5:0] F_SUBU = 6'h23;
    localparam logic [5:0] F_AND  = 6'h24;
    localparam logic [5:0] F_OR   = 6'h25;
    localparam logic [5:0] F_SLT  = 6'h2a;

    logic        clk, rstN, instEn, memEn, dCacheStall;
    logic [31:0] instAddr, instr, memAddr, memRdata, memWdata;
    logic [3:0]  memWen;

    logic [31:0] rom [0:255];
    logic [31:0] dataRam [0:63];
    logic [31:0] modelReg [0:31];
    logic [31:0] modelMem [0:63];
    logic [31:0] expAddr [0:255];   // ordered store list from the model
    logic [31:0] expData [0:255];
    integer      expCount, storeCount, errors, cycles, seed, k;

    mipsCore dut0 (
        .clk_i(clk), .rstN_i(rstN),
        .instAddr_o(instAddr), .instEn_o(instEn), .instr_i(instr),
        .memEn_o(memEn), .memAddr_o(memAddr), .memRdata_i(memRdata),
        .memWen_o(memWen), .memWdata_o(memWdata),
        .dCacheStall_i(dCacheStall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign instr    = rom[instAddr[9:2]];  // combinational fetch
    assign memRdata = dataRam[memAddr[7:2]];

    function automatic logic [31:0] initWord(input integer idx);
        return 32'h1357_0000 + idx * 32'h0004_0001;
    endfunction

    // fill during reset and commit stores on an unstalled edge
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 64; i++)
                dataRam[i] <= initWord(i);
        end else if (memWen != 4'h0 && !dCacheStall) begin
            dataRam[memAddr[7:2]] <= memWdata;
        end
    end

    function automatic integer randBelow(input integer n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] funct);
        return {6'b000000, rs, rt, rd, 5'b00000, funct};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input logic [25:0] target);
        return {mipsPkg::OP_J, target};
    endfunction

    function automatic logic [5:0] aluFunct(input integer n);
        case (n)
            0:       return F_ADDU;
            1:       return F_SUBU;
            2:       return F_AND;
            3:       return F_OR;
            default: return F_SLT;
        endcase
    endfunction

    task automatic buildProgram;
        integer      i, kind;
        logic [4:0]  rs, rt, rd;
        logic [31:0] r;
        for (i = 0; i < 15; i++) begin
            r = $random(seed);
            rom[i] = encI(mipsPkg::OP_ADDIU, 5'd0, 5'(i + 1), r[15:0]);
        end
        for (i = 15; i < DUMP_AT; i++) begin
            kind = randBelow(16);
            rs   = 5'(randBelow(16));   // sources may be $0
            rt   = 5'(randBelow(16));
            rd   = 5'(1 + randBelow(15));
            r    = $random(seed);
            if (kind >= 13 && i >= DUMP_AT - 5)
                kind = 7;               // keep branch targets ahead of the dump
            if (kind <= 6)
                rom[i] = encR(rs, rt, rd, aluFunct(randBelow(5)));
            else if (kind <= 8)
                rom[i] = encI(mipsPkg::OP_ADDIU, rs, rd, r[15:0]);
            else if (kind <= 10)
                rom[i] = encI(mipsPkg::OP_LW, 5'd0, rd, 16'(randBelow(64) * 4));
            else if (kind <= 12)
                rom[i] = encI(mipsPkg::OP_SW, 5'd0, rt, 16'(randBelow(64) * 4));
            else if (kind == 13)
                rom[i] = encI(mipsPkg::OP_BEQ, rs, r[0] ? rs : rt, 16'(1 + randBelow(4)));
            else if (kind == 14)
                rom[i] = encI(mipsPkg::OP_BNE, rs, rt, 16'(1 + randBelow(4)));
            else
                rom[i] = encJ(26'(i + 2 + randBelow(4)));
        end
        for (i = 1; i <= 15; i++)
            rom[DUMP_AT + i - 1] = encI(mipsPkg::OP_SW, 5'd0, 5'(i), 16'((47 + i) * 4));
        rom[LOOP_AT] = encJ(26'(LOOP_AT));  // park here
        for (i = LOOP_AT + 1; i < 256; i++)
            rom[i] = 32'h0;
    endtask

    // in-order ISA model without delay slots
    task automatic runModel;
        integer      pc, nextPc, steps, idx;
        logic [31:0] ins, a, b, simm, addr, val;
        logic [4:0]  dst;
        logic        wr;
        for (idx = 0; idx < 32; idx++)
            modelReg[idx] = 32'h0;
        for (idx = 0; idx < 64; idx++)
            modelMem[idx] = initWord(idx);
        pc       = 0;
        steps    = 0;
        expCount = 0;
        while (pc != LOOP_AT && steps < 4 * PROG_LEN) begin
            ins    = rom[pc];
            a      = modelReg[ins[25:21]];
            b      = modelReg[ins[20:16]];
            simm   = {{16{ins[15]}}, ins[15:0]};
            addr   = a + simm;
            val    = a + simm;
            dst    = ins[20:16];
            wr     = 1'b0;
            nextPc = pc + 1;
            case (ins[31:26])
                mipsPkg::OP_SPECIAL: begin
                    wr  = 1'b1;
                    dst = ins[15:11];
                    case (ins[5:0])
                        F_ADDU:  val = a + b;
                        F_SUBU:  val = a - b;
                        F_AND:   val = a & b;
                        F_OR:    val = a | b;
                        F_SLT:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                mipsPkg::OP_ADDIU: wr = 1'b1;
                mipsPkg::OP_LW: begin
                    wr  = 1'b1;
                    val = modelMem[addr[7:2]];
                end
                mipsPkg::OP_SW: begin
                    modelMem[addr[7:2]] = b;
                    expAddr[expCount]   = addr;
                    expData[expCount]   = b;
                    expCount++;
                end
                mipsPkg::OP_BEQ: if (a == b) nextPc = pc + 1 + $signed(simm);
                mipsPkg::OP_BNE: if (a != b) nextPc = pc + 1 + $signed(simm);
                mipsPkg::OP_J:   nextPc = {6'b000000, ins[25:0]};
                default: ;
            endcase
            if (wr && dst != 5'd0)
                modelReg[dst] = val;
            pc = nextPc;
            steps++;
        end
        if (pc != LOOP_AT) begin
            $display("reference model never reached the final loop");
            errors++;
        end
    endtask

    task automatic checkQuietReset;
        if (memEn !== 1'b0) begin
            $display("FAILED %0t memEn_o expected 0 got %b", $time, memEn);
            errors++;
        end
        if (memWen !== 4'h0) begin
            $display("FAILED %0t memWen_o expected 0 got %h", $time, memWen);
            errors++;
        end
        if (instEn !== 1'b0) begin
            $display("FAILED %0t instEn_o expected 0 got %b", $time, instEn);
            errors++;
        end
    endtask

    task automatic checkStore;
        if (storeCount >= expCount) begin
            $display("store beyond the expected list at %0t to %h", $time, memAddr);
            errors++;
        end else begin
            if (memAddr !== expAddr[storeCount]) begin
                $display("FAILED %0t memAddr_o expected %h got %h",
                         $time, expAddr[storeCount], memAddr);
                errors++;
            end
            if (memWdata !== expData[storeCount]) begin
                $display("FAILED %0t memWdata_o expected %h got %h",
                         $time, expData[storeCount], memWdata);
                errors++;
            end
            if (memWen !== 4'hf) begin
                $display("FAILED %0t memWen_o expected f got %h", $time, memWen);
                errors++;
            end
            storeCount++;
        end
    endtask

    // new stall level, then see whether the coming edge commits a store
    task automatic stepCycle;
        @(negedge clk);
        cycles = cycles + 1;
        if (dCacheStall && instEn !== 1'b0) begin   // last stall level still applies
            $display("FAILED %0t instEn_o expected 0 got %b", $time, instEn);
            errors++;
        end
        dCacheStall = (randBelow(4) == 0);
        if (memWen != 4'h0 && !dCacheStall)
            checkStore;
    endtask

    initial begin
        seed        = 91186;
        errors      = 0;
        cycles      = 0;
        storeCount  = 0;
        rstN        = 1'b0;
        dCacheStall = 1'b0;
        buildProgram;
        runModel;
        @(negedge clk);
        checkQuietReset;
        @(negedge clk);
        checkQuietReset;
        rstN = 1'b1;
        @(posedge clk);     // edge that takes the first fetch
        if (instEn !== 1'b1) begin
            $display("FAILED %0t instEn_o expected 1 got %b", $time, instEn);
            errors++;
        end
        if (instAddr !== `RESET_PC) begin
            $display("FAILED %0t instAddr_o expected %h got %h",
                     $time, `RESET_PC, instAddr);
            errors++;
        end
        while (storeCount < expCount && cycles < CYCLE_LIMIT)
            stepCycle;
        if (storeCount < expCount) begin
            $display("timeout after %0d cycles, %0d of %0d stores committed",
                     cycles, storeCount, expCount);
            errors++;
        end else begin
            repeat (8) stepCycle;   // stray wrong-path stores would land here
        end
        for (k = 0; k < 64; k++) begin
            if (dataRam[k] !== modelMem[k]) begin
                $display("FAILED %0t dataRam[%0d] expected %h got %h",
                         $time, k, modelMem[k], dataRam[k]);
                errors++;
            end
        end
        errors = errors + dut0.props0.failCount;
        $display("errors %0d, stores %0d of %0d, cycles %0d",
                 errors, storeCount, expCount, cycles);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- list.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/mainDecoder.sv
verilog/hazardUnit.sv
verilog/datapath.sv
verilog/mipsCore.sv
verification/mipsCore_props.sv
verification/mipsCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mipsCoreTb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
